/* compile.f */
src/apb_pkg.sv
src/ivmu_pkg.sv
src/ivmu_regfile.sv
src/ivmu_prio_enc.sv
src/ivmu_vector_hs.sv
src/apb_ivmu.sv
tb/tb_apb_ivmu.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

top=tb_apb_ivmu
log=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module "$top" \
    -f compile.f \
    -o "$top"

./obj_dir/"$top" | tee "$log"

if grep -q "TESTS FAILED" "$log"; then
    echo "simulation failed, see $log"
    exit 1
fi
if ! grep -q "TESTS PASSED" "$log"; then
    echo "simulation ended without a result, see $log"
    exit 1
fi
echo "simulation passed"

/* src/apb_ivmu.sv */
// APB interrupt vector unit top; no wait states, irq_in assumed synchronous to pclk
`default_nettype none

module apb_ivmu (
    input  wire logic                   pclk,
    input  wire logic                   preset_n,
    input  wire apb_pkg::apb_req_t      apb,
    input  wire ivmu_pkg::irq_t         irq_in,
    input  wire logic                   vector_ack,
    output logic [apb_pkg::data_w-1:0]  prdata,
    output ivmu_pkg::vector_t           vector,
    output logic                        irq_out,
    output logic                        vector_req
);

    // Masked interrupt lines
    ivmu_pkg::irq_t              pending;

    // Encoder result
    ivmu_pkg::prio_t             prio;

    // Handshake side table read port
    logic [ivmu_pkg::idx_w-1:0]  vec_idx;
    ivmu_pkg::vector_t           vec_entry;

    // Registers, masking and APB access
    ivmu_regfile u_regfile (
        .pclk      (pclk),
        .preset_n  (preset_n),
        .apb       (apb),
        .irq_in    (irq_in),
        .vec_idx   (vec_idx),
        .prdata    (prdata),
        .pending   (pending),
        .vec_entry (vec_entry)
    );

    // Lowest pending index wins
    ivmu_prio_enc u_prio_enc (
        .pending (pending),
        .prio    (prio)
    );

    // Vector delivery over req/ack
    ivmu_vector_hs u_vector_hs (
        .pclk       (pclk),
        .preset_n   (preset_n),
        .prio       (prio),
        .vec_entry  (vec_entry),
        .vector_ack (vector_ack),
        .vec_idx    (vec_idx),
        .vector     (vector),
        .vector_req (vector_req)
    );

    // Any unmasked line, outside the handshake
    // Follows irq_in with no delay
    assign irq_out = |pending;

endmodule

`default_nettype wire

/* src/apb_pkg.sv */
// APB3-style bus without pready or pslverr; slaves here respond with zero wait states
`default_nettype none

package apb_pkg;

    // Bus widths
    localparam int addr_w = 8;
    localparam int data_w = 32;

    // Master-driven side of the bus
    // Byte-addressed, but table entries sit on consecutive addresses
    typedef struct packed {
        logic [addr_w-1:0] paddr;
        logic              pwrite;
        logic [data_w-1:0] pwdata;
        logic              psel;
        logic              penable;
    } apb_req_t;

    // Access phase of a write transfer
    function automatic logic is_write(apb_req_t req);
        return req.psel & req.penable & req.pwrite;
    endfunction

    // Access phase of a read transfer
    function automatic logic is_read(apb_req_t req);
        return req.psel & req.penable & ~req.pwrite;
    endfunction

endpackage

`default_nettype wire

/* src/ivmu_pkg.sv */
// Interrupt vector unit definitions; register addresses assume an 8-bit APB address bus
`default_nettype none

package ivmu_pkg;

    // Interrupt line count and index width
    localparam int num_irq = 16;
    localparam int idx_w   = 4;

    // Vector table entry width
    localparam int vec_w   = 32;

    // One bit per line, for irq_in, mask and pending
    typedef logic [num_irq-1:0] irq_t;

    // Single vector table entry
    typedef logic [vec_w-1:0] vector_t;

    // Priority encoder result
    // idx only meaningful when valid is set
    typedef struct packed {
        logic [idx_w-1:0] idx;
        logic             valid;
    } prio_t;

    // Register map
    // Table entry n lives at address n, so 8'h00 to 8'h0F
    localparam logic [7:0] addr_tbl_first = 8'h00;
    localparam logic [7:0] addr_tbl_last  = 8'h0F;
    // Mask, low 16 bits of the data bus
    localparam logic [7:0] addr_mask      = 8'h40;
    // Masked interrupt lines, read only
    localparam logic [7:0] addr_pending   = 8'h44;

    // Reset values
    localparam vector_t vec_reset_base = 32'hE000_0000;
    localparam int      vec_reset_step = 256;
    // All lines masked out of reset
    localparam irq_t    mask_reset     = '1;

    // Reset value of table entry n
    function automatic vector_t vec_reset(int unsigned n);
        return vec_reset_base + vector_t'(n * vec_reset_step);
    endfunction

    // True when an address falls inside the vector table
    function automatic logic is_tbl_addr(logic [7:0] addr);
        return (addr >= addr_tbl_first) && (addr <= addr_tbl_last);
    endfunction

endpackage

`default_nettype wire

/* src/ivmu_prio_enc.sv */
// Fixed-priority encoder, line 0 highest; purely combinational
`default_nettype none

module ivmu_prio_enc (
    input  wire ivmu_pkg::irq_t pending,
    output ivmu_pkg::prio_t     prio
);

    // Any line at all
    logic any_pending;

    assign any_pending = |pending;

    // Scan from the lowest priority upward
    // Last hit wins, so the lowest set index is kept
    always_comb begin
        prio.idx = '0;
        for (int i = ivmu_pkg::num_irq - 1; i >= 0; i--) begin
            if (pending[i]) begin
                prio.idx = i[ivmu_pkg::idx_w-1:0];
            end
        end
        // idx stays zero when nothing is pending
        prio.valid = any_pending;
    end

endmodule

`default_nettype wire

/* src/ivmu_regfile.sv */
// Zero-wait-state APB slave; prdata registered on the access edge, irq_in must be pclk-synchronous
`default_nettype none

module ivmu_regfile (
    input  wire logic                             pclk,
    input  wire logic                             preset_n,
    input  wire apb_pkg::apb_req_t                apb,
    input  wire ivmu_pkg::irq_t                   irq_in,
    input  wire logic [ivmu_pkg::idx_w-1:0]       vec_idx,
    output logic [apb_pkg::data_w-1:0]            prdata,
    output ivmu_pkg::irq_t                        pending,
    output ivmu_pkg::vector_t                     vec_entry
);

    // Vector table and line mask
    ivmu_pkg::vector_t tbl [ivmu_pkg::num_irq];
    ivmu_pkg::irq_t    mask;

    // Decoded access strobes
    logic wr_en;
    logic rd_en;

    // Address decode
    logic                         tbl_hit;
    logic [ivmu_pkg::idx_w-1:0]   tbl_sel;

    // Read data selected for the current address
    logic [apb_pkg::data_w-1:0]   rd_data;

    assign wr_en = apb_pkg::is_write(apb);
    assign rd_en = apb_pkg::is_read(apb);

    // Entry n sits at address n, so low bits pick the entry
    assign tbl_hit = ivmu_pkg::is_tbl_addr(apb.paddr);
    assign tbl_sel = apb.paddr[ivmu_pkg::idx_w-1:0];

    // Set mask bit removes that line
    assign pending = irq_in & ~mask;

    // Second read port for the handshake controller
    // Independent of any APB cycle
    assign vec_entry = tbl[vec_idx];

    // Table writes
    // Reset loads base plus 256 per entry
    always_ff @(posedge pclk or negedge preset_n) begin
        if (!preset_n) begin
            for (int n = 0; n < ivmu_pkg::num_irq; n++) begin
                tbl[n] <= ivmu_pkg::vec_reset(n);
            end
        end else if (wr_en && tbl_hit) begin
            tbl[tbl_sel] <= apb.pwdata;
        end
    end

    // Mask write
    // Only the low 16 data bits land, the rest are dropped
    always_ff @(posedge pclk or negedge preset_n) begin
        if (!preset_n) begin
            mask <= ivmu_pkg::mask_reset;
        end else if (wr_en && (apb.paddr == ivmu_pkg::addr_mask)) begin
            mask <= apb.pwdata[ivmu_pkg::num_irq-1:0];
        end
    end

    // Read mux
    // Mask and pending come back zero-extended
    always_comb begin
        rd_data = '0;
        if (tbl_hit) begin
            rd_data = tbl[tbl_sel];
        end else begin
            case (apb.paddr)
                ivmu_pkg::addr_mask: begin
                    rd_data[ivmu_pkg::num_irq-1:0] = mask;
                end
                ivmu_pkg::addr_pending: begin
                    // Live view, not a sampled copy
                    rd_data[ivmu_pkg::num_irq-1:0] = pending;
                end
                default: begin
                    // Unmapped addresses read zero
                    rd_data = '0;
                end
            endcase
        end
    end

    // prdata loads on the access edge and holds until the next read
    always_ff @(posedge pclk or negedge preset_n) begin
        if (!preset_n) begin
            prdata <= '0;
        end else if (rd_en) begin
            prdata <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* src/ivmu_vector_hs.sv */
// Level req/ack handshake; vector frozen while requesting, at least one idle cycle between requests
`default_nettype none

module ivmu_vector_hs (
    input  wire logic                         pclk,
    input  wire logic                         preset_n,
    input  wire ivmu_pkg::prio_t              prio,
    input  wire ivmu_pkg::vector_t            vec_entry,
    input  wire logic                         vector_ack,
    output logic [ivmu_pkg::idx_w-1:0]        vec_idx,
    output ivmu_pkg::vector_t                 vector,
    output logic                              vector_req
);

    // Request machine
    typedef enum logic {
        st_idle = 1'b0,
        st_req  = 1'b1
    } state_t;

    state_t state;
    state_t state_nxt;

    // Table lookup follows the current winner
    assign vec_idx = prio.idx;

    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            st_idle: begin
                // Something pending, raise the request next edge
                if (prio.valid) begin
                    state_nxt = st_req;
                end
            end
            st_req: begin
                // Low ack is back-pressure, just hold
                if (vector_ack) begin
                    state_nxt = st_idle;
                end
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    always_ff @(posedge pclk or negedge preset_n) begin
        if (!preset_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // Vector capture
    // Only on leaving idle, so later table or mask changes never reach it
    always_ff @(posedge pclk or negedge preset_n) begin
        if (!preset_n) begin
            vector <= '0;
        end else if ((state == st_idle) && prio.valid) begin
            vector <= vec_entry;
        end
    end

    // Request is the state itself, glitch free
    assign vector_req = (state == st_req);

endmodule

`default_nettype wire

/* tb/tb_apb_ivmu.sv */
// Inputs change on falling pclk edges only; zero-wait APB and irq_in synchronous to pclk assumed
`default_nettype none

module tb_apb_ivmu;

    // Iterations per random test
    localparam int n_mask = 24;
    localparam int n_prio = 24;
    localparam int n_hs   = 16;
    // Reset check, readback, then every random iteration
    localparam int num_steps      = 2 + n_mask + n_prio + n_hs;
    localparam int timeout_cycles = num_steps * 200 + 500;
    localparam int req_wait_max   = 20;

    logic                       pclk;
    logic                       preset_n;
    apb_pkg::apb_req_t          apb;
    ivmu_pkg::irq_t             irq_in;
    logic                       vector_ack;
    logic [apb_pkg::data_w-1:0] prdata;
    ivmu_pkg::vector_t          vector;
    logic                       irq_out;
    logic                       vector_req;

    // Model of the table and mask that follows every issued write
    ivmu_pkg::vector_t shadow_tbl [16];
    ivmu_pkg::irq_t    shadow_mask;

    logic [31:0] lfsr         = 32'h2804;
    int          val_errors   = 0;
    int          other_errors = 0;
    logic        checking     = 1'b0;

    // Values seen in the cycle before a rising edge
    logic              cap_valid;
    ivmu_pkg::vector_t cap_exp;
    logic              cap_req;
    logic              cap_ack;
    ivmu_pkg::vector_t cap_vector;

    apb_ivmu u_apb_ivmu (
        .pclk       (pclk),
        .preset_n   (preset_n),
        .apb        (apb),
        .irq_in     (irq_in),
        .vector_ack (vector_ack),
        .prdata     (prdata),
        .vector     (vector),
        .irq_out    (irq_out),
        .vector_req (vector_req)
    );

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // Expected vector of the lowest unmasked line
    // Return value is low when no line is pending
    function automatic logic exp_vector(input ivmu_pkg::irq_t irq, input ivmu_pkg::irq_t msk,
                                        output ivmu_pkg::vector_t vec);
        ivmu_pkg::irq_t pend;
        logic           found;
        pend  = irq & ~msk;
        found = 1'b0;
        vec   = '0;
        for (int i = 0; i < 16; i++) begin
            if (pend[i] && !found) begin
                vec   = shadow_tbl[i];
                found = 1'b1;
            end
        end
        return found;
    endfunction

    // Setup, access, idle
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge pclk);
        apb.paddr   = addr;
        apb.pwrite  = 1'b1;
        apb.pwdata  = data;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        @(negedge pclk);
        apb.penable = 1'b1;
        @(posedge pclk);
        // Model updates on the access edge
        // Writes to pending and unmapped addresses are dropped
        if (addr <= 8'h0F) begin
            shadow_tbl[addr[3:0]] = data;
        end else if (addr == ivmu_pkg::addr_mask) begin
            shadow_mask = data[15:0];
        end
        @(negedge pclk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
        apb.pwrite  = 1'b0;
    endtask

    // prdata checked in the idle cycle after the access edge
    task automatic apb_read(input logic [7:0] addr, input logic [31:0] exp);
        @(negedge pclk);
        apb.paddr   = addr;
        apb.pwrite  = 1'b0;
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        @(negedge pclk);
        apb.penable = 1'b1;
        @(negedge pclk);
        apb.psel    = 1'b0;
        apb.penable = 1'b0;
        assert (prdata === exp) else begin
            val_errors++;
            $display("mismatch at %0t: read 0x%02h gave 0x%08h, expected 0x%08h",
                     $time, addr, prdata, exp);
        end
    endtask

    task automatic wait_req();
        int n;
        n = 0;
        @(negedge pclk);
        while (!vector_req && n < req_wait_max) begin
            @(negedge pclk);
            n++;
        end
        assert (vector_req) else begin
            other_errors++;
            $display("vector_req did not rise within %0d cycles (at %0t)", req_wait_max, $time);
        end
    endtask

    // One-cycle ack with irq_in moving to next_irq on the same edge
    task automatic give_ack(input ivmu_pkg::irq_t next_irq);
        @(negedge pclk);
        vector_ack = 1'b1;
        irq_in     = next_irq;
        @(negedge pclk);
        vector_ack = 1'b0;
    endtask

    // Capture after the falling edge and check after the rising edge
    always begin
        @(negedge pclk);
        #1;
        cap_valid  = exp_vector(irq_in, shadow_mask, cap_exp);
        cap_req    = vector_req;
        cap_ack    = vector_ack;
        cap_vector = vector;
        @(posedge pclk);
        #1;
        if (checking) begin
            assert (irq_out == |(irq_in & ~shadow_mask)) else begin
                val_errors++;
                $display("mismatch at %0t: irq_out is %b, expected %b",
                         $time, irq_out, |(irq_in & ~shadow_mask));
            end
            if (cap_req && cap_ack) begin
                assert (!vector_req) else begin
                    val_errors++;
                    $display("mismatch at %0t: vector_req still high after ack", $time);
                end
            end else if (cap_req) begin
                // Waiting request must not move
                assert (vector_req && vector == cap_vector) else begin
                    val_errors++;
                    $display("mismatch at %0t: held request moved, vector 0x%08h was 0x%08h",
                             $time, vector, cap_vector);
                end
            end else begin
                assert (vector_req == cap_valid) else begin
                    val_errors++;
                    $display("mismatch at %0t: vector_req is %b, expected %b",
                             $time, vector_req, cap_valid);
                end
                if (cap_valid) begin
                    assert (vector == cap_exp) else begin
                        val_errors++;
                        $display("mismatch at %0t: vector 0x%08h, expected 0x%08h",
                                 $time, vector, cap_exp);
                    end
                end
            end
        end
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge pclk);
        $display("timeout: run did not finish within %0d clock cycles", timeout_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0]    r;
        ivmu_pkg::irq_t m;
        ivmu_pkg::irq_t irq;
        logic [3:0]     idx;
        int             hold;
        logic           keep;
        apb        = '0;
        irq_in     = '0;
        vector_ack = 1'b0;
        preset_n   = 1'b0;
        // Entry n resets to E000_0000 plus n times 256
        for (int n = 0; n < 16; n++) begin
            shadow_tbl[n] = 32'hE000_0000 + 32'(n) * 32'h100;
        end
        shadow_mask = 16'hFFFF;
        repeat (8) @(posedge pclk);
        @(negedge pclk);
        preset_n = 1'b1;
        checking = 1'b1;

        // Reset values
        assert (!vector_req && !irq_out && vector == '0 && prdata == '0) else begin
            val_errors++;
            $display("mismatch at %0t: outputs not at their reset values", $time);
        end
        for (int n = 0; n < 16; n++) begin
            apb_read(8'(n), shadow_tbl[n]);
        end
        apb_read(ivmu_pkg::addr_mask, 32'h0000_FFFF);
        // Every line masked so nothing shows as pending
        rand_bits(16, r);
        irq_in = r[15:0];
        apb_read(ivmu_pkg::addr_pending, 32'h0);
        apb_read(8'h20, 32'h0);
        apb_read(8'hFC, 32'h0);
        irq_in = '0;

        // Write and read back
        // Pending and unmapped writes leave no trace
        for (int n = 0; n < 16; n++) begin
            rand_bits(32, r);
            apb_write(8'(n), r);
        end
        rand_bits(32, r);
        apb_write(ivmu_pkg::addr_mask, r);
        rand_bits(32, r);
        apb_write(ivmu_pkg::addr_pending, r);
        apb_write(8'h10, r);
        apb_write(8'h80, r);
        for (int n = 0; n < 16; n++) begin
            apb_read(8'(n), shadow_tbl[n]);
        end
        apb_read(ivmu_pkg::addr_mask, {16'h0, shadow_mask});
        apb_read(ivmu_pkg::addr_pending, 32'h0);
        apb_read(8'h10, 32'h0);

        // Masking with ack held high so requests come and go
        vector_ack = 1'b1;
        for (int i = 0; i < n_mask; i++) begin
            rand_bits(16, r);
            m = r[15:0];
            apb_write(ivmu_pkg::addr_mask, {16'h0, m});
            rand_bits(16, r);
            irq_in = r[15:0];
            apb_read(ivmu_pkg::addr_pending, {16'h0, irq_in & ~shadow_mask});
        end
        irq_in = '0;
        repeat (2) @(negedge pclk);
        vector_ack = 1'b0;

        // Priority delivery with the lowest pending entry rewritten first
        for (int i = 0; i < n_prio; i++) begin
            rand_bits(4, r);
            idx = r[3:0];
            rand_bits(16, r);
            irq = (r[15:0] | (16'h1 << idx)) & ~((16'h1 << idx) - 16'h1);
            rand_bits(16, r);
            m = r[15:0] & ~(16'h1 << idx);
            apb_write(ivmu_pkg::addr_mask, {16'h0, m});
            rand_bits(32, r);
            apb_write({4'h0, idx}, r);
            irq_in = irq;
            wait_req();
            give_ack('0);
        end

        // Back-pressure with irq_in and mask moving under a waiting request
        apb_write(ivmu_pkg::addr_mask, 32'h0);
        for (int i = 0; i < n_hs; i++) begin
            rand_bits(16, r);
            irq_in = r[15:0] | 16'h8000;
            wait_req();
            rand_bits(3, r);
            hold = int'(r[2:0]) + 1;
            repeat (hold) begin
                @(negedge pclk);
                rand_bits(16, r);
                irq_in = r[15:0];
            end
            rand_bits(16, r);
            apb_write(ivmu_pkg::addr_mask, {16'h0, r[15:0]});
            apb_write(ivmu_pkg::addr_mask, 32'h0);
            rand_bits(1, r);
            keep = r[0];
            give_ack(keep ? 16'h0010 : 16'h0000);
            if (keep) begin
                // Line 4 still pending so a new request is due
                wait_req();
                give_ack('0);
            end else begin
                repeat (4) @(negedge pclk);
                assert (!vector_req) else begin
                    val_errors++;
                    $display("mismatch at %0t: vector_req rose although no line was pending",
                             $time);
                end
            end
        end

        repeat (2) @(negedge pclk);
        $display("errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
        if (val_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
